// ==== source/gf_pkg.sv ====
/* shared field constants, Wishbone types, register map and enums for the GF(2^8) coprocessor
   RTL and testbench reference these by scoped name */
`default_nettype none

package gf_pkg;

	// field element width and primitive polynomial without the x^8 term
	localparam int field_width = 8;
	localparam logic [7:0] field_poly = 8'h1D; // x^8 + x^4 + x^3 + x^2 + 1

	// one field element at the package default width for the software model
	typedef logic [field_width-1:0] gf_elem_t;

	// Wishbone classic data and word address
	typedef logic [31:0] wb_data_t;
	typedef logic [2:0] wb_addr_t;

	// word addresses of the host-visible registers
	localparam wb_addr_t reg_operand_a = 3'd0;
	localparam wb_addr_t reg_operand_b = 3'd1;
	localparam wb_addr_t reg_command = 3'd2;
	localparam wb_addr_t reg_status = 3'd3; // read only
	localparam wb_addr_t reg_result = 3'd4; // read only

	// bit positions inside the status word whose other bits read as zero
	localparam int status_busy_bit = 0;
	localparam int status_done_bit = 1;
	localparam int status_zero_div_bit = 2;

	// the decoder rejects code 0 and codes above 5
	typedef enum logic [2:0] {
		cmd_mul = 3'd1, // a * b
		cmd_sqr = 3'd2, // a * a
		cmd_cube = 3'd3, // a * a * a
		cmd_inv = 3'd4, // a^-1
		cmd_div = 3'd5 // a / b
	} gf_cmd_t;

	// execute FSM states
	typedef enum logic [1:0] {
		st_idle, // waiting for start
		st_iterate, // Fermat square-and-accumulate steps
		st_finish // result capture that takes two cycles for a divide
	} exec_state_t;

endpackage

`default_nettype wire

// ==== source/gf_mult.sv ====
/* combinational standard-basis GF(2^M) multiplier, product = a_in * b_in mod POLY
   instantiate with the field width and reduction polynomial of the design */
`timescale 1ns/1ns
`default_nettype none

module gf_mult #(
	parameter int M = 8,
	parameter logic [M-1:0] POLY = 8'h1D
) (
	input wire logic [M-1:0] a_in,
	input wire logic [M-1:0] b_in,
	output logic [M-1:0] product
);

	// rows[i] holds a_in * alpha^i, already reduced
	logic [M-1:0] rows [M];

	// rows selected by the bits of b_in
	logic [M-1:0] picked [M];

	assign rows[0] = a_in; // alpha^0 row is the operand itself

	// each row is the previous one shifted up by one power of alpha
	for (genvar i = 1; i < M; i++) begin : g_row
		// the bit shifted out of the top folds back in through the polynomial
		assign rows[i] = {rows[i-1][M-2:0], 1'b0} ^ ({M{rows[i-1][M-1]}} & POLY);
	end

	// a row only takes part when the matching coefficient of b_in is one
	for (genvar i = 0; i < M; i++) begin : g_pick
		assign picked[i] = rows[i] & {M{b_in[i]}};
	end

	// addition in the field is a plain XOR of all the selected rows
	always_comb begin
		product = '0;
		for (int i = 0; i < M; i++) begin
			product = product ^ picked[i];
		end
	end

endmodule

`default_nettype wire

// ==== source/gf_cube.sv ====
/* combinational cube network for GF(2^M) in standard basis, cube = value^3 mod POLY
   one level of AND gates and a constant XOR matrix, no multiplier needed */
`timescale 1ns/1ns
`default_nettype none

module gf_cube #(
	parameter int M = 8,
	parameter logic [M-1:0] POLY = 8'h1D
) (
	input wire logic [M-1:0] value,
	output logic [M-1:0] cube
);

	// alpha^n reduced by POLY, evaluated only while elaborating
	function automatic logic [M-1:0] alpha_pow(input int n);
		logic [M-1:0] acc;
		acc = M'(1);
		for (int k = 0; k < n; k++) begin
			acc = {acc[M-2:0], 1'b0} ^ (acc[M-1] ? POLY : '0);
		end
		return acc;
	endfunction

	logic [M-1:0] single_terms [M]; // a_i * alpha^(3i)
	logic [M-1:0] pair_terms [M][M]; // a_i * a_j * (alpha^(2i+j) + alpha^(2j+i)) for i < j

	for (genvar i = 0; i < M; i++) begin : g_bit
		localparam logic [M-1:0] single_col = alpha_pow(3 * i);

		assign single_terms[i] = value[i] ? single_col : '0;

		for (genvar j = 0; j < M; j++) begin : g_pair
			if (j > i) begin : g_upper
				// both cross products of the pair land in one constant column
				localparam logic [M-1:0] pair_col = alpha_pow(2 * i + j) ^ alpha_pow(2 * j + i);

				assign pair_terms[i][j] = (value[i] & value[j]) ? pair_col : '0;
			end else begin : g_lower
				assign pair_terms[i][j] = '0; // diagonal is in single_terms, lower half is a repeat
			end
		end
	end

	// sum of every term gives the cube
	always_comb begin
		cube = '0;
		for (int i = 0; i < M; i++) begin
			cube = cube ^ single_terms[i];
			for (int j = 0; j < M; j++) begin
				cube = cube ^ pair_terms[i][j];
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/gf_op_decode.sv ====
/* Wishbone classic slave of the coprocessor, holds operands and command and pulses start
   single cycle ack with no wait states, reads return operands, command, status or result */
`timescale 1ns/1ns
`default_nettype none

module gf_op_decode #(
	parameter int M = 8
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic wb_cyc,
	input wire logic wb_stb,
	input wire logic wb_we,
	input wire gf_pkg::wb_addr_t wb_adr,
	input wire gf_pkg::wb_data_t wb_dat_w,
	output gf_pkg::wb_data_t wb_dat_r,
	output logic wb_ack,
	output logic [M-1:0] operand_a,
	output logic [M-1:0] operand_b,
	output gf_pkg::gf_cmd_t cmd,
	output logic start,
	input wire logic busy,
	input wire logic done,
	input wire logic zero_div,
	input wire logic [M-1:0] result
);

	logic access; // a new bus cycle is accepted on this edge
	logic write; // accepted cycle is a write
	logic cmd_valid; // written word is one of the five command codes
	logic engine_free; // execute can take a new command
	gf_pkg::wb_data_t status_word;
	gf_pkg::wb_data_t read_word;

	assign access = wb_cyc & wb_stb & ~wb_ack; // ack low means this cycle has not been answered
	assign write = access & wb_we;
	assign cmd_valid = (wb_dat_w >= gf_pkg::wb_data_t'(gf_pkg::cmd_mul)) &&
		(wb_dat_w <= gf_pkg::wb_data_t'(gf_pkg::cmd_div));
	assign engine_free = ~busy & ~start; // start in flight counts as busy for one cycle

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_ack <= 1'b0;
			start <= 1'b0;
		end else begin
			wb_ack <= access; // high for exactly the one cycle after the request is seen
			start <= write && (wb_adr == gf_pkg::reg_command) && cmd_valid && engine_free;
		end
	end

	// operands and command only change while execute is idle, so they hold through an operation
	always_ff @(posedge clk) begin
		if (write && engine_free) begin
			if (wb_adr == gf_pkg::reg_operand_a)
				operand_a <= wb_dat_w[M-1:0];
			if (wb_adr == gf_pkg::reg_operand_b)
				operand_b <= wb_dat_w[M-1:0];
			if (wb_adr == gf_pkg::reg_command && cmd_valid)
				cmd <= gf_pkg::gf_cmd_t'(wb_dat_w[2:0]); // last accepted command
		end
	end

	always_comb begin
		status_word = '0;
		status_word[gf_pkg::status_busy_bit] = busy;
		status_word[gf_pkg::status_done_bit] = done;
		status_word[gf_pkg::status_zero_div_bit] = zero_div;
	end

	// field values are zero extended to the bus width
	always_comb begin
		case (wb_adr)
			gf_pkg::reg_operand_a: read_word = gf_pkg::wb_data_t'(operand_a);
			gf_pkg::reg_operand_b: read_word = gf_pkg::wb_data_t'(operand_b);
			gf_pkg::reg_command: read_word = gf_pkg::wb_data_t'(cmd);
			gf_pkg::reg_status: read_word = status_word;
			gf_pkg::reg_result: read_word = gf_pkg::wb_data_t'(result);
			default: read_word = '0; // unmapped addresses read as zero
		endcase
	end

	always_ff @(posedge clk) begin
		if (access)
			wb_dat_r <= read_word; // captured with ack so it is valid while ack is high
	end

endmodule

`default_nettype wire

// ==== source/gf_op_execute.sv ====
/* operation engine of the coprocessor, one-step MUL, SQR and CUBE plus Fermat INV and DIV
   owns the result register and the busy, done and zero_div flags read back over the bus */
`timescale 1ns/1ns
`default_nettype none

module gf_op_execute #(
	parameter int M = 8,
	parameter logic [M-1:0] POLY = 8'h1D
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic start,
	input wire gf_pkg::gf_cmd_t cmd,
	input wire logic [M-1:0] operand_a,
	input wire logic [M-1:0] operand_b,
	output logic [M-1:0] result,
	output logic busy,
	output logic done,
	output logic zero_div
);

	localparam int step_w = $clog2(M);
	localparam logic [step_w-1:0] last_step = step_w'(M - 2); // M-1 iterations, counted from 0

	// alpha^(2i), the image of basis bit i under squaring
	function automatic logic [M-1:0] square_column(input int i);
		logic [M-1:0] col;
		col = M'(1);
		for (int k = 0; k < 2 * i; k++) begin
			col = {col[M-2:0], 1'b0} ^ (col[M-1] ? POLY : '0);
		end
		return col;
	endfunction

	gf_pkg::exec_state_t state;
	logic [step_w-1:0] step; // iteration count, reused as the divide phase in st_finish
	logic [M-1:0] square; // running a^(2^k)
	logic [M-1:0] acc; // running product of the squares, ends as the inverse
	logic inv_cmd; // command goes through the Fermat loop
	logic div_mul_step; // first finish cycle of a divide
	logic [M-1:0] inv_src; // element to invert, INV takes A and DIV takes B
	logic [M-1:0] sq_in;
	logic [M-1:0] sq_out;
	logic [M-1:0] sq_terms [M];
	logic [M-1:0] main_product;
	logic [M-1:0] acc_product;
	logic [M-1:0] cube_out;
	logic [M-1:0] finish_value;

	assign inv_cmd = (cmd == gf_pkg::cmd_inv) || (cmd == gf_pkg::cmd_div);
	assign div_mul_step = (cmd == gf_pkg::cmd_div) && (step == '0);
	assign inv_src = (cmd == gf_pkg::cmd_div) ? operand_b : operand_a;
	assign sq_in = (state == gf_pkg::st_iterate) ? square : inv_src; // inv_src is A outside DIV

	// squaring is linear in GF(2^M), each set input bit adds one constant column
	for (genvar i = 0; i < M; i++) begin : g_square
		localparam logic [M-1:0] col = square_column(i);

		assign sq_terms[i] = sq_in[i] ? col : '0;
	end

	always_comb begin
		sq_out = '0;
		for (int i = 0; i < M; i++) begin
			sq_out = sq_out ^ sq_terms[i];
		end
	end

	// A * B for MUL, A * B^-1 for the divide step
	gf_mult #(.M(M), .POLY(POLY)) u_mul_main (
		.a_in(operand_a),
		.b_in((cmd == gf_pkg::cmd_div) ? acc : operand_b),
		.product(main_product)
	);

	// accumulator times the current square, one Fermat step
	gf_mult #(.M(M), .POLY(POLY)) u_mul_acc (
		.a_in(acc),
		.b_in(square),
		.product(acc_product)
	);

	gf_cube #(.M(M), .POLY(POLY)) u_cube (
		.value(operand_a),
		.cube(cube_out)
	);

	always_comb begin
		case (cmd)
			gf_pkg::cmd_mul: finish_value = main_product;
			gf_pkg::cmd_sqr: finish_value = sq_out;
			gf_pkg::cmd_cube: finish_value = cube_out;
			default: finish_value = acc; // INV, and DIV once the multiply has been folded in
		endcase
	end

	// datapath, preloaded every idle cycle so the start edge leaves a^2 and 1 behind
	always_ff @(posedge clk) begin
		if (state == gf_pkg::st_idle) begin
			square <= sq_out;
			acc <= M'(1);
		end else if (state == gf_pkg::st_iterate) begin
			square <= sq_out;
			acc <= acc_product;
		end else if (div_mul_step) begin
			acc <= main_product; // B^-1 becomes A * B^-1
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= gf_pkg::st_idle;
			step <= '0;
			busy <= 1'b0;
			done <= 1'b0;
			zero_div <= 1'b0;
			result <= '0;
		end else begin
			case (state)
				gf_pkg::st_idle: begin
					if (start) begin
						busy <= 1'b1;
						done <= 1'b0;
						// a zero element runs through the loop and comes out as 0 by itself
						zero_div <= inv_cmd && (inv_src == '0);
						step <= '0;
						state <= inv_cmd ? gf_pkg::st_iterate : gf_pkg::st_finish;
					end
				end
				gf_pkg::st_iterate: begin
					step <= step + 1'b1;
					if (step == last_step) begin
						step <= '0;
						state <= gf_pkg::st_finish;
					end
				end
				default: begin
					if (div_mul_step) begin
						step <= step + 1'b1; // one extra cycle for the multiply by A
					end else begin
						result <= finish_value;
						done <= 1'b1;
						busy <= 1'b0;
						state <= gf_pkg::st_idle;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/gf_coproc_top.sv ====
/* top level of the GF(2^8) coprocessor, a Wishbone classic slave
   sets the field width and polynomial and connects the bus decoder to the engine */
`timescale 1ns/1ns
`default_nettype none

module gf_coproc_top #(
	parameter int M = gf_pkg::field_width,
	parameter logic [M-1:0] POLY = gf_pkg::field_poly
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic wb_cyc,
	input wire logic wb_stb,
	input wire logic wb_we,
	input wire gf_pkg::wb_addr_t wb_adr,
	input wire gf_pkg::wb_data_t wb_dat_w,
	output gf_pkg::wb_data_t wb_dat_r,
	output logic wb_ack
);

	logic [M-1:0] operand_a;
	logic [M-1:0] operand_b;
	gf_pkg::gf_cmd_t cmd;
	logic start; // one cycle pulse per accepted command
	logic busy;
	logic done;
	logic zero_div;
	logic [M-1:0] result;

	gf_op_decode #(.M(M)) u_decode (
		.clk(clk),
		.reset(reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.operand_a(operand_a),
		.operand_b(operand_b),
		.cmd(cmd),
		.start(start),
		.busy(busy),
		.done(done),
		.zero_div(zero_div),
		.result(result)
	);

	gf_op_execute #(.M(M), .POLY(POLY)) u_execute (
		.clk(clk),
		.reset(reset),
		.start(start),
		.cmd(cmd),
		.operand_a(operand_a),
		.operand_b(operand_b),
		.result(result),
		.busy(busy),
		.done(done),
		.zero_div(zero_div)
	);

endmodule

`default_nettype wire

// ==== bench/clock_gen.sv ====
/* testbench clock with an 8 ns period and a synchronous active high reset
   reset is high from time zero and drops on the edge that ends the 16th cycle */
`timescale 1ns/1ns
`default_nettype none

module clock_gen (
	output logic clk,
	output logic reset
);

	localparam int half_period = 4; // ns, gives the 8 ns period
	localparam int reset_cycles = 16;

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	initial begin
		reset = 1'b1; // DUT sees reset from the very first edge
		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b0; // released on a rising edge like every other stimulus
	end

endmodule

`default_nettype wire

// ==== bench/gf_coproc_assertions.sv ====
/* concurrent checks on the Wishbone handshake and the engine flags of the coprocessor
   bound into every gf_coproc_top instance by the bind statement at the end */
`timescale 1ns/1ns
`default_nettype none

module gf_coproc_assertions (
	input wire logic clk,
	input wire logic reset,
	input wire logic wb_cyc,
	input wire logic wb_stb,
	input wire logic wb_ack,
	input wire logic busy,
	input wire logic done,
	input wire logic zero_div
);

	// the slave answers with a one cycle pulse and never stretches it
	ack_single_cycle: assert property (@(posedge clk) disable iff (reset)
		wb_ack |=> !wb_ack)
		else $error("wb_ack was high for more than one cycle");

	// an ack must answer a request that was open and not yet answered one cycle earlier
	ack_after_request: assert property (@(posedge clk) disable iff (reset)
		wb_ack |-> $past(wb_cyc && wb_stb && !wb_ack))
		else $error("wb_ack rose without a pending cyc and stb");

	// done is only set as busy drops, and start clears done as busy rises
	busy_done_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(busy && done))
		else $error("busy and done were high together");

	// not disabled by reset, it looks at the cycle right after a reset edge
	flags_clear_after_reset: assert property (@(posedge clk)
		reset |=> !(busy || done || zero_div || wb_ack))
		else $error("a flag or ack was set right after reset");

endmodule

// hooks the checks onto the top level nets of the coprocessor
bind gf_coproc_top gf_coproc_assertions u_assertions (
	.clk(clk),
	.reset(reset),
	.wb_cyc(wb_cyc),
	.wb_stb(wb_stb),
	.wb_ack(wb_ack),
	.busy(busy),
	.done(done),
	.zero_div(zero_div)
);

`default_nettype wire

// ==== bench/gf_coproc_tb.sv ====
/* testbench for the GF(2^8) coprocessor that drives the Wishbone port as a classic master
   and checks every result against a shift-and-reduce field model */
`timescale 1ns/1ns
`default_nettype none

module gf_coproc_tb;

	localparam int bus_timeout = 20; // cycles to wait for one ack
	localparam int poll_limit = 100; // status reads before an operation counts as hung
	localparam int reset_timeout = 64;
	localparam int elem_w = gf_pkg::field_width;

	logic clk;
	logic reset;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	gf_pkg::wb_addr_t wb_adr;
	gf_pkg::wb_data_t wb_dat_w;
	gf_pkg::wb_data_t wb_dat_r;
	logic wb_ack;

	int checks = 0;
	int errors = 0;
	int test_checks; // totals when the current test began
	int test_errors;
	string test_name;

	clock_gen u_clock (.clk(clk), .reset(reset));

	gf_coproc_top dut0 (
		.clk(clk),
		.reset(reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack)
	);

	// multiply by shifting a up one power of alpha per bit of b and folding the carry back
	function automatic gf_pkg::gf_elem_t model_mul(input gf_pkg::gf_elem_t a,
		input gf_pkg::gf_elem_t b);
		gf_pkg::gf_elem_t p;
		gf_pkg::gf_elem_t x;
		p = '0;
		x = a;
		for (int i = 0; i < elem_w; i++) begin
			if (b[i])
				p = p ^ x;
			x = {x[elem_w-2:0], 1'b0} ^ (x[elem_w-1] ? gf_pkg::field_poly : '0);
		end
		return p;
	endfunction

	// status of a finished operation has busy low and done high
	function automatic gf_pkg::wb_data_t expected_status(input logic zero_div);
		gf_pkg::wb_data_t word;
		word = '0;
		word[gf_pkg::status_done_bit] = 1'b1;
		word[gf_pkg::status_zero_div_bit] = zero_div;
		return word;
	endfunction

	task automatic abort_run(input string why);
		$display("run stopped at %0t ns: %s", $time, why);
		$display("Checks failed");
		$finish;
	endtask

	task automatic check_value(input string name, input gf_pkg::wb_data_t got,
		input gf_pkg::wb_data_t expected);
		checks++;
		assert (got === expected) else begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s got 0x%0h expected 0x%0h",
				$time, name, got, expected);
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_checks = checks;
		test_errors = errors;
	endtask

	task automatic end_test();
		$display("test %s finished: %0d checks, %0d failed", test_name,
			checks - test_checks, errors - test_errors);
	endtask

	task automatic wait_reset_release();
		int waited;
		waited = 0;
		while (reset && waited < reset_timeout) begin
			@(negedge clk); // reset changes on rising edges only
			waited++;
		end
		if (reset)
			abort_run("reset was never released");
	endtask

	// one classic cycle drives the request on a rising edge and samples ack on the falling edge
	task automatic bus_cycle(input logic we, input gf_pkg::wb_addr_t addr,
		input gf_pkg::wb_data_t data, output gf_pkg::wb_data_t rdata);
		int waited;
		waited = 0;
		rdata = '0;
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_adr <= addr;
		wb_dat_w <= data;
		@(negedge clk);
		while (!wb_ack && waited < bus_timeout) begin
			waited++;
			@(negedge clk);
		end
		if (!wb_ack) begin
			abort_run("no ack on the Wishbone bus");
		end else begin
			rdata = wb_dat_r; // read data is valid while ack is high
			@(posedge clk);
			wb_cyc <= 1'b0; // request held until ack was seen
			wb_stb <= 1'b0;
			wb_we <= 1'b0;
		end
	endtask

	task automatic bus_write(input gf_pkg::wb_addr_t addr, input gf_pkg::wb_data_t data);
		gf_pkg::wb_data_t unused;
		bus_cycle(1'b1, addr, data, unused);
	endtask

	task automatic bus_read(input gf_pkg::wb_addr_t addr, output gf_pkg::wb_data_t data);
		bus_cycle(1'b0, addr, '0, data);
	endtask

	// latency varies with the command, so status is polled until done is set and busy is clear
	task automatic wait_done(output gf_pkg::wb_data_t status);
		int polls;
		polls = 0;
		bus_read(gf_pkg::reg_status, status);
		while ((!status[gf_pkg::status_done_bit] || status[gf_pkg::status_busy_bit]) &&
			polls < poll_limit) begin
			polls++;
			bus_read(gf_pkg::reg_status, status);
		end
		if (!status[gf_pkg::status_done_bit] || status[gf_pkg::status_busy_bit])
			abort_run("operation did not finish in time");
	endtask

	task automatic run_op(input gf_pkg::gf_cmd_t op, input gf_pkg::gf_elem_t a,
		input gf_pkg::gf_elem_t b, output gf_pkg::wb_data_t res,
		output gf_pkg::wb_data_t status);
		bus_write(gf_pkg::reg_operand_a, gf_pkg::wb_data_t'(a));
		bus_write(gf_pkg::reg_operand_b, gf_pkg::wb_data_t'(b));
		bus_write(gf_pkg::reg_command, gf_pkg::wb_data_t'(op));
		wait_done(status);
		bus_read(gf_pkg::reg_result, res);
	endtask

	initial begin
		gf_pkg::wb_data_t word;
		gf_pkg::wb_data_t status;
		gf_pkg::wb_data_t res;
		gf_pkg::wb_data_t kept;
		gf_pkg::gf_elem_t a;
		gf_pkg::gf_elem_t b;
		gf_pkg::gf_elem_t values [$];

		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		void'($urandom(43)); // one fixed seed for the whole run
		wait_reset_release();

		begin_test("reset_and_handshake");
		bus_read(gf_pkg::reg_status, word);
		check_value("status after reset", word, '0);
		bus_read(gf_pkg::reg_result, word);
		check_value("result after reset", word, '0);
		bus_write(gf_pkg::reg_operand_a, 32'h0000_005A);
		bus_read(gf_pkg::reg_operand_a, word);
		check_value("operand_a readback", word, 32'h0000_005A);
		// read only registers acknowledge writes and a command code written there starts nothing
		bus_write(gf_pkg::reg_status, gf_pkg::wb_data_t'(gf_pkg::cmd_mul));
		bus_write(gf_pkg::reg_result, gf_pkg::wb_data_t'(gf_pkg::cmd_mul));
		bus_read(gf_pkg::reg_status, word);
		check_value("status after write", word, '0);
		bus_read(gf_pkg::reg_result, word);
		check_value("result after write", word, '0);
		end_test();

		begin_test("mul");
		repeat (40) begin
			a = gf_pkg::gf_elem_t'($urandom_range(255, 0));
			b = gf_pkg::gf_elem_t'($urandom_range(255, 0));
			run_op(gf_pkg::cmd_mul, a, b, res, status);
			check_value("result of mul", res, gf_pkg::wb_data_t'(model_mul(a, b)));
			check_value("status after mul", status, expected_status(1'b0));
		end
		end_test();

		begin_test("sqr_and_cube");
		values.push_back(8'h00);
		values.push_back(8'h01);
		repeat (12) values.push_back(gf_pkg::gf_elem_t'($urandom_range(255, 2)));
		foreach (values[i]) begin
			a = values[i];
			run_op(gf_pkg::cmd_sqr, a, 8'h00, res, status);
			check_value("result of sqr", res, gf_pkg::wb_data_t'(model_mul(a, a)));
			run_op(gf_pkg::cmd_cube, a, 8'h00, res, status);
			check_value("result of cube", res,
				gf_pkg::wb_data_t'(model_mul(model_mul(a, a), a)));
			check_value("status after cube", status, expected_status(1'b0));
		end
		end_test();

		begin_test("inv");
		for (int v = 1; v < 256; v++) begin
			a = gf_pkg::gf_elem_t'(v);
			run_op(gf_pkg::cmd_inv, a, 8'h00, res, status);
			check_value("operand times inverse", model_mul(a, res[elem_w-1:0]), 1);
			check_value("status after inv", status, expected_status(1'b0));
		end
		run_op(gf_pkg::cmd_inv, 8'h00, 8'h00, res, status);
		check_value("result of inv of zero", res, '0);
		check_value("status after inv of zero", status, expected_status(1'b1));
		run_op(gf_pkg::cmd_mul, 8'h03, 8'h05, res, status); // any valid start clears zero_div
		check_value("status after next command", status, expected_status(1'b0));
		end_test();

		begin_test("div");
		repeat (20) begin
			a = gf_pkg::gf_elem_t'($urandom_range(255, 0));
			b = gf_pkg::gf_elem_t'($urandom_range(255, 1));
			run_op(gf_pkg::cmd_div, a, b, res, status);
			check_value("quotient times divisor", model_mul(res[elem_w-1:0], b), a);
			check_value("status after div", status, expected_status(1'b0));
		end
		run_op(gf_pkg::cmd_div, 8'hA7, 8'h00, res, status);
		check_value("result of div by zero", res, '0);
		check_value("status after div by zero", status, expected_status(1'b1));
		end_test();

		begin_test("ignored_commands");
		bus_write(gf_pkg::reg_operand_a, 32'h0000_0053);
		bus_write(gf_pkg::reg_command, gf_pkg::wb_data_t'(gf_pkg::cmd_inv));
		bus_write(gf_pkg::reg_command, gf_pkg::wb_data_t'(gf_pkg::cmd_mul)); // lands while busy
		wait_done(status);
		bus_read(gf_pkg::reg_result, res);
		check_value("inverse after busy write", model_mul(8'h53, res[elem_w-1:0]), 1);
		bus_read(gf_pkg::reg_command, word);
		check_value("command register", word, gf_pkg::wb_data_t'(gf_pkg::cmd_inv));
		kept = res;
		bus_write(gf_pkg::reg_command, 32'h0000_0000);
		bus_read(gf_pkg::reg_status, status);
		check_value("status after code 0", status, expected_status(1'b0));
		bus_read(gf_pkg::reg_result, res);
		check_value("result after code 0", res, kept);
		bus_write(gf_pkg::reg_command, 32'h0000_0007);
		bus_read(gf_pkg::reg_status, status);
		check_value("status after code 7", status, expected_status(1'b0));
		bus_read(gf_pkg::reg_result, res);
		check_value("result after code 7", res, kept);
		end_test();

		$display("%0d checks run, %0d failed", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/gf_pkg.sv
source/gf_mult.sv
source/gf_cube.sv
source/gf_op_decode.sv
source/gf_op_execute.sv
source/gf_coproc_top.sv
bench/clock_gen.sv
bench/gf_coproc_assertions.sv
bench/gf_coproc_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the coprocessor testbench with Verilator, run it and scan the log for failures
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module gf_coproc_tb \
	-f vlog.f -o gf_coproc_sim || { echo "build failed"; exit 1; }
./obj_dir/gf_coproc_sim > sim.log 2>&1 || echo "simulator exited with an error status" >> sim.log
cat sim.log
grep -q -e "Checks failed" -e "%Error" -e "simulator exited" sim.log && { echo "FAIL"; exit 1; }
echo "PASS"
exit 0
